//--- common/spectrum_pkg.sv
package spectrum_pkg;

    //////////////////////////////
    // Sample memory
    //////////////////////////////
    localparam int sample_width   = 16;                // One FFT magnitude
    localparam int addr_width     = 10;
    localparam int sample_entries = 1 << addr_width;   // 1024 words

    //////////////////////////////
    // Bins and display
    //////////////////////////////
    localparam int max_bins        = 6;
    localparam int bin_index_width = 3;
    localparam int energy_width    = 42;   // 1024 squared samples fit
    localparam int intensity_width = 14;   // One color slot

    // Packed word widths on the top level ports
    localparam int ends_width  = max_bins * addr_width;       // 60
    localparam int color_width = max_bins * intensity_width;  // 84

    // Sequencer to accumulator, lined up with the read data
    typedef struct packed {
        logic                       sample;  // Read issued this step
        logic                       close;   // Last step of the bin
        logic [bin_index_width-1:0] bin;
    } bin_step_t;

    // Accumulator to mapper
    typedef struct packed {
        logic                       valid;
        logic                       final_bin;  // Last bin of the run
        logic [bin_index_width-1:0] bin;
        logic [energy_width-1:0]    energy;
    } bin_energy_t;

endpackage

//--- logic/sample_store.sv
module sample_store (
    input  logic                                clock,
    input  logic                                write,
    input  logic [spectrum_pkg::addr_width-1:0]   write_addr,
    input  logic [spectrum_pkg::sample_width-1:0] write_data,
    input  logic [spectrum_pkg::addr_width-1:0]   read_addr,
    output logic [spectrum_pkg::sample_width-1:0] read_data
);

    import spectrum_pkg::*;

    // Block RAM style array, contents undefined until filled
    logic [sample_width-1:0] mem [0:sample_entries-1];

    //////////////////////////////
    // Write port
    //////////////////////////////
    always_ff @(posedge clock) begin
        if (write) begin
            mem[write_addr] <= write_data;
        end
    end

    //////////////////////////////
    // Read port
    //////////////////////////////
    // One cycle latency, read runs every cycle
    always_ff @(posedge clock) begin
        read_data <= mem[read_addr];
    end

endmodule

//--- energy/bin_sequencer.sv
module bin_sequencer #(
    parameter int drain_cycles = 3
) (
    input  logic                                   clock,
    input  logic                                   arst_n,
    input  logic                                   start,
    input  logic [spectrum_pkg::bin_index_width-1:0] bin_count,
    input  logic [spectrum_pkg::ends_width-1:0]      bin_ends,
    output logic [spectrum_pkg::addr_width-1:0]      read_addr,
    output spectrum_pkg::bin_step_t                  step,
    output logic                                   run_begin,
    output logic                                   final_bin,
    output logic                                   busy
);

    import spectrum_pkg::*;

    localparam int drain_width = $clog2(drain_cycles + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_walk,
        st_empty,   // Bin with no addresses, one close step
        st_drain
    } state_t;

    state_t                     state;
    logic [addr_width-1:0]      cur_addr;
    logic [ends_width-1:0]      ends_hold;   // Current bin end in the low slot
    logic [bin_index_width-1:0] bin_idx;
    logic [bin_index_width-1:0] last_idx;    // Index of last requested bin
    logic [drain_width-1:0]     drain_cnt;

    logic [addr_width-1:0]      bin_end;
    logic [addr_width-1:0]      next_end;
    logic [bin_index_width-1:0] count_last;
    logic                       last_addr;
    logic                       last_bin;
    logic                       advance;

    assign bin_end  = ends_hold[addr_width-1:0];
    assign next_end = ends_hold[2*addr_width-1:addr_width];

    // Clamp requested count into 1..max_bins, keep it as last index
    always_comb begin
        if (bin_count == '0) begin
            count_last = '0;
        end else if (bin_count > bin_index_width'(max_bins)) begin
            count_last = bin_index_width'(max_bins - 1);
        end else begin
            count_last = bin_count - 1'b1;
        end
    end

    assign last_addr = (cur_addr == bin_end - 1'b1);
    assign last_bin  = (bin_idx == last_idx);
    // Bin closes this cycle
    assign advance   = ((state == st_walk) && last_addr) || (state == st_empty);

    assign read_addr = cur_addr;            // Store only reads what walk asks
    assign busy      = (state != st_idle);

    //////////////////////////////
    // Walk state machine
    //////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state     <= st_idle;
            cur_addr  <= '0;
            ends_hold <= '0;
            bin_idx   <= '0;
            last_idx  <= '0;
            drain_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        ends_hold <= bin_ends;
                        last_idx  <= count_last;
                        cur_addr  <= '0;
                        bin_idx   <= '0;
                        // Bin 0 starts at address 0
                        state <= (bin_ends[addr_width-1:0] != '0) ? st_walk : st_empty;
                    end
                end
                st_walk, st_empty: begin
                    if (advance) begin
                        if (last_bin) begin
                            state     <= st_drain;
                            drain_cnt <= drain_width'(drain_cycles - 1);
                        end else begin
                            // Next bin starts at this bin's end
                            cur_addr  <= bin_end;
                            ends_hold <= ends_hold >> addr_width;
                            bin_idx   <= bin_idx + 1'b1;
                            state     <= (next_end > bin_end) ? st_walk : st_empty;
                        end
                    end else begin
                        cur_addr <= cur_addr + 1'b1;
                    end
                end
                st_drain: begin
                    if (drain_cnt == '0) begin
                        state <= st_idle;   // Pipeline empty by now
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    //////////////////////////////
    // Step register
    //////////////////////////////
    // Delayed one cycle to meet the store's read data
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            step      <= '0;
            final_bin <= 1'b0;
            run_begin <= 1'b0;
        end else begin
            step.sample <= (state == st_walk);
            step.close  <= advance;
            step.bin    <= bin_idx;
            final_bin   <= advance && last_bin;
            run_begin   <= (state == st_idle) && start;   // Start accepted
        end
    end

endmodule

//--- energy/energy_accumulator.sv
module energy_accumulator (
    input  logic                                clock,
    input  logic                                arst_n,
    input  spectrum_pkg::bin_step_t               step,
    input  logic                                final_bin,
    input  logic [spectrum_pkg::sample_width-1:0] read_data,
    output spectrum_pkg::bin_energy_t             energy_out
);

    import spectrum_pkg::*;

    logic [energy_width-1:0]   sum;       // Running bin energy
    logic [2*sample_width-1:0] product;
    logic [energy_width-1:0]   total;

    // Square only when this step carried a read
    assign product = step.sample ? read_data * read_data : '0;
    assign total   = sum + energy_width'(product);

    //////////////////////////////
    // Sum and emit
    //////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sum        <= '0;
            energy_out <= '0;
        end else begin
            energy_out.valid     <= step.close;
            energy_out.final_bin <= final_bin;
            energy_out.bin       <= step.bin;
            energy_out.energy    <= total;   // Includes this sample
            if (step.close) begin
                sum <= '0;    // Fresh start for next bin
            end else begin
                sum <= total;
            end
        end
    end

endmodule

//--- logic/intensity_mapper.sv
module intensity_mapper #(
    parameter int energy_shift = 20
) (
    input  logic                               clock,
    input  logic                               arst_n,
    input  logic                               run_begin,
    input  spectrum_pkg::bin_energy_t            energy_in,
    output logic [spectrum_pkg::color_width-1:0] color,
    output logic                               done
);

    import spectrum_pkg::*;

    logic [energy_width-1:0]    shifted;
    logic [intensity_width-1:0] level;
    logic                       final_seen;   // Last slot written

    // Scale down, clip at the slot maximum
    assign shifted = energy_in.energy >> energy_shift;
    assign level   = (|shifted[energy_width-1:intensity_width]) ? '1
                                                                : shifted[intensity_width-1:0];

    //////////////////////////////
    // Color slots
    //////////////////////////////
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            color <= '0;
        end else if (run_begin) begin
            color <= '0;   // Whole word cleared per run
        end else if (energy_in.valid) begin
            for (int k = 0; k < max_bins; k++) begin
                if (energy_in.bin == bin_index_width'(k)) begin
                    color[k*intensity_width +: intensity_width] <= level;
                end
            end
        end
    end

    // Done trails the final slot update by one cycle
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            final_seen <= 1'b0;
            done       <= 1'b0;
        end else begin
            final_seen <= energy_in.valid && energy_in.final_bin;
            done       <= final_seen;
        end
    end

endmodule

//--- logic/spectrum_energy_top.sv
module spectrum_energy_top #(
    parameter int energy_shift = 20,
    parameter int drain_cycles = 3
) (
    input  logic                                   clock,
    input  logic                                   arst_n,
    input  logic                                   sample_write,
    input  logic [spectrum_pkg::addr_width-1:0]      sample_addr,
    input  logic [spectrum_pkg::sample_width-1:0]    sample_data,
    input  logic                                   start,
    input  logic [spectrum_pkg::bin_index_width-1:0] bin_count,
    input  logic [spectrum_pkg::ends_width-1:0]      bin_ends,
    output logic                                   busy,
    output logic                                   done,
    output logic [spectrum_pkg::color_width-1:0]     color
);

    import spectrum_pkg::*;

    logic [addr_width-1:0]   read_addr;
    logic [sample_width-1:0] read_data;
    bin_step_t               step;
    logic                    final_bin;
    logic                    run_begin;
    bin_energy_t             energy;

    //////////////////////////////
    // Memory and control
    //////////////////////////////
    sample_store u_store (
        .clock      (clock),
        .write      (sample_write),
        .write_addr (sample_addr),
        .write_data (sample_data),
        .read_addr  (read_addr),
        .read_data  (read_data)
    );

    bin_sequencer #(
        .drain_cycles (drain_cycles)
    ) u_sequencer (
        .clock     (clock),
        .arst_n    (arst_n),
        .start     (start),
        .bin_count (bin_count),
        .bin_ends  (bin_ends),
        .read_addr (read_addr),
        .step      (step),
        .run_begin (run_begin),
        .final_bin (final_bin),
        .busy      (busy)
    );

    //////////////////////////////
    // Energy datapath
    //////////////////////////////
    energy_accumulator u_accumulator (
        .clock      (clock),
        .arst_n     (arst_n),
        .step       (step),
        .final_bin  (final_bin),
        .read_data  (read_data),
        .energy_out (energy)
    );

    intensity_mapper #(
        .energy_shift (energy_shift)
    ) u_mapper (
        .clock     (clock),
        .arst_n    (arst_n),
        .run_begin (run_begin),
        .energy_in (energy),
        .color     (color),
        .done      (done)
    );

endmodule

//--- testbench/spectrum_assert.sv
module spectrum_assert (
    input logic                                 clock,
    input logic                                 arst_n,
    input logic                                 busy,
    input logic                                 done,
    input logic [spectrum_pkg::color_width-1:0] color
);

    timeunit 1ns;
    timeprecision 100ps;

    //////////////////////////////
    // Control strobes
    //////////////////////////////
    // Single cycle done pulse
    done_one_cycle: assert property (
        @(posedge clock) disable iff (!arst_n)
        done |=> !done
    ) else $error("done stayed high for more than one cycle");

    // A run must have been in progress
    done_after_busy: assert property (
        @(posedge clock) disable iff (!arst_n)
        $rose(done) |-> $past(busy)
    ) else $error("done rose without a preceding busy phase");

    busy_low_at_reset_exit: assert property (
        @(posedge clock)
        $rose(arst_n) |-> !busy && !done
    ) else $error("busy or done high when reset was released");

    //////////////////////////////
    // Result word
    //////////////////////////////
    // Color holds between runs
    color_stable_idle: assert property (
        @(posedge clock) disable iff (!arst_n)
        !busy |-> $stable(color)
    ) else $error("color changed while the block was idle");

endmodule

//--- testbench/spectrum_tb.sv
module spectrum_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import spectrum_pkg::*;

    localparam int    clock_period = 100;
    localparam string data_path    = "testbench/spectrum_testdata.txt";

    // One record of the data file
    typedef struct packed {
        logic [7:0]       kind;    // F, R or E
        logic [7:0][31:0] field;   // Numbers in file order
    } record_t;

    logic                       clock;
    logic                       arst_n;
    logic                       sample_write;
    logic [addr_width-1:0]      sample_addr;
    logic [sample_width-1:0]    sample_data;
    logic                       start;
    logic [bin_index_width-1:0] bin_count;
    logic [ends_width-1:0]      bin_ends;
    logic                       busy;
    logic                       done;
    logic [color_width-1:0]     color;

    record_t records[$];
    int      run_total;     // Sizes the watchdog
    int      fill_total;
    int      run_index;
    logic    limit_ready;

    spectrum_energy_top #(
        .energy_shift (20),
        .drain_cycles (3)
    ) dut (
        .clock        (clock),
        .arst_n       (arst_n),
        .sample_write (sample_write),
        .sample_addr  (sample_addr),
        .sample_data  (sample_data),
        .start        (start),
        .bin_count    (bin_count),
        .bin_ends     (bin_ends),
        .busy         (busy),
        .done         (done),
        .color        (color)
    );

    bind spectrum_energy_top spectrum_assert u_assert (
        .clock  (clock),
        .arst_n (arst_n),
        .busy   (busy),
        .done   (done),
        .color  (color)
    );

    always #(clock_period / 2) clock = ~clock;

    //////////////////////////////
    // Reporting
    //////////////////////////////
    // Wide enough for the whole color word
    task automatic check_value(input logic [color_width-1:0] actual,
                               input logic [color_width-1:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s, got %0d expected %0d", $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "run aborted");
    endtask

    //////////////////////////////
    // Data file
    //////////////////////////////
    task automatic load_records();
        int               fd;
        int               got;
        int               value;
        int               n_fields;
        logic [63:0]      token;
        logic [8*128-1:0] rest;
        record_t          rec;
        fd = $fopen(data_path, "r");
        if (fd == 0) begin
            abort_run("Could not open the test data file");
        end
        while (!$feof(fd)) begin
            token = '0;
            got   = $fscanf(fd, "%s", token);
            if (got != 1) begin
                break;   // Trailing blank lines
            end
            if (token == "#") begin
                got = $fgets(rest, fd);   // Skip the comment line
            end else if (token == "F" || token == "R" || token == "E") begin
                rec      = '0;
                rec.kind = token[7:0];
                n_fields = (token == "F") ? 3 : (token == "R") ? 8 : 6;
                for (int i = 0; i < n_fields; i++) begin
                    got = $fscanf(fd, "%d", value);
                    if (got != 1) begin
                        abort_run("Test data file ends in the middle of a record");
                    end
                    rec.field[i] = value;
                end
                if (token == "F") fill_total++;
                if (token == "R") run_total++;
                records.push_back(rec);
            end else begin
                abort_run("Test data file holds an unknown record type");
            end
        end
        $fclose(fd);
    endtask

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    // One write per cycle, last address excluded
    task automatic fill_range(input int first, input int last, input int value);
        for (int a = first; a < last; a++) begin
            @(negedge clock);
            sample_write = 1'b1;
            sample_addr  = addr_width'(a);
            sample_data  = sample_width'(value);
        end
        @(negedge clock);
        sample_write = 1'b0;
    endtask

    task automatic run_bins(input record_t rec);
        logic [ends_width-1:0] ends;
        run_index++;
        for (int k = 0; k < max_bins; k++) begin
            ends[k*addr_width +: addr_width] = addr_width'(rec.field[k+1]);
        end
        @(negedge clock);
        start     = 1'b1;
        bin_count = bin_index_width'(rec.field[0]);
        bin_ends  = ends;
        @(negedge clock);
        start = 1'b0;
        check_value(busy, 1, "busy after accepted start");
        check_value(done, 0, "done right after start");
        if (rec.field[7] != 0) begin
            // Different settings that must be ignored
            @(negedge clock);
            start     = 1'b1;
            bin_count = bin_index_width'(max_bins);
            bin_ends  = '1;
            @(negedge clock);
            start = 1'b0;
            check_value(busy, 1, "busy while start pulsed again");
        end
        while (!done) @(negedge clock);   // Watchdog bounds this
        check_value(busy, 0, "busy when done rises");
        repeat (4) begin
            @(negedge clock);
            check_value(done, 0, "done repeated or held");
            check_value(busy, 0, "busy after run end");
        end
    endtask

    task automatic check_color(input record_t rec);
        for (int k = 0; k < max_bins; k++) begin
            check_value(color[k*intensity_width +: intensity_width], rec.field[k],
                        $sformatf("intensity of bin %0d in run %0d", k, run_index));
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial begin
        clock        = 1'b0;
        arst_n       = 1'b0;
        sample_write = 1'b0;
        sample_addr  = '0;
        sample_data  = '0;
        start        = 1'b0;
        bin_count    = '0;
        bin_ends     = '0;
        run_total    = 0;
        fill_total   = 0;
        run_index    = 0;
        limit_ready  = 1'b0;
        load_records();
        limit_ready = 1'b1;
        repeat (3) @(negedge clock);   // Three rising edges in reset
        arst_n = 1'b1;
        @(negedge clock);
        check_value(busy, 0, "busy after reset");
        check_value(done, 0, "done after reset");
        check_value(color, 0, "color after reset");
        foreach (records[i]) begin
            case (records[i].kind)
                "F": fill_range(records[i].field[0], records[i].field[1], records[i].field[2]);
                "R": run_bins(records[i]);
                "E": check_color(records[i]);
                default: ;
            endcase
        end
        $display("No errors");
        $finish;
    end

    // Limit grows with the number of runs and fills
    initial begin : watchdog
        int limit;
        wait (limit_ready);
        limit = run_total * 1100 + fill_total * 1024 + 100;
        repeat (limit) @(posedge clock);
        abort_run($sformatf("Timeout after %0d clock cycles, the DUT did not finish", limit));
    end

endmodule

//--- testbench/spectrum_testdata.txt
# F  first  last  value                 fills addresses first up to last-1 with value
# R  count  end0 .. end5  restart       runs the bins, restart 1 pulses start while busy
# E  slot0 .. slot5                     expected intensities of the run before
# Single bin over a filled range
F 0 100 1000
R 1 100 0 0 0 0 0 0
E 95 0 0 0 0 0
# Six bins with their own constants, bin 3 saturates
F 0 64 2000
F 64 192 3000
F 192 320 500
F 320 512 60000
F 512 768 1024
F 768 1024 4096
R 6 64 192 320 512 768 1023 0
E 244 1098 30 16383 256 4080
# Empty bin 1 with three bins requested
R 3 64 64 192 500 600 700 0
E 244 0 1098 0 0 0
# Start pulsed again while busy
R 4 64 192 320 512 0 0 1
E 244 1098 30 16383 0 0
# New fills and a shorter run replace the whole color word
F 0 128 256
F 128 384 8192
R 2 128 384 0 0 0 0 0
E 8 16383 0 0 0 0

//--- files.f
common/spectrum_pkg.sv
logic/sample_store.sv
energy/bin_sequencer.sv
energy/energy_accumulator.sv
logic/intensity_mapper.sv
logic/spectrum_energy_top.sv
testbench/spectrum_assert.sv
testbench/spectrum_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= spectrum_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
